// ==== all.f ====
+incdir+src
src/rv_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/alu.sv
src/exec_unit.sv
src/rv_core.sv
bench/retire_checker.sv
bench/tb_top.sv

// ==== bench/program_input.txt ====
# p  address  word      program word, both hex
# r  pc  rd  value      expected retirement in order (rd 0 = no write, value x = illegal)
p 80000000 00500093
p 80000004 ffd00113
p 80000008 402081b3
p 8000000c 00112233
p 80000010 001132b3
p 80000014 40115333
p 80000018 00415393
p 8000001c 00309433
p 80000020 0ff44493
p 80000024 0f04f513
p 80000028 001565b3
p 8000002c 12345637
p 80000030 00001697
p 80000034 00708013
p 80000038 00108463
p 80000040 00208463
p 80000044 00209463
p 8000004c 00109463
p 80000050 00114463
p 80000058 0020c463
p 8000005c 0020d463
p 80000064 00115463
p 80000068 0020e463
p 80000070 00116463
p 80000074 00117463
p 8000007c 0020f463
p 80000080 00c0076f
p 8000008c 00000797
p 80000090 00d78867
p 80000098 0040a183
p 8000009c 00e188b3
p 800000a0 00900913
r 80000000 1 00000005
r 80000004 2 fffffffd
r 80000008 3 00000008
r 8000000c 4 00000001
r 80000010 5 00000000
r 80000014 6 ffffffff
r 80000018 7 0fffffff
r 8000001c 8 00000500
r 80000020 9 000005ff
r 80000024 10 000000f0
r 80000028 11 000000f5
r 8000002c 12 12345000
r 80000030 13 80001030
r 80000034 0 00000000
r 80000038 0 00000000
r 80000040 0 00000000
r 80000044 0 00000000
r 8000004c 0 00000000
r 80000050 0 00000000
r 80000058 0 00000000
r 8000005c 0 00000000
r 80000064 0 00000000
r 80000068 0 00000000
r 80000070 0 00000000
r 80000074 0 00000000
r 8000007c 0 00000000
r 80000080 14 80000084
r 8000008c 15 8000008c
r 80000090 16 80000094
r 80000098 0 x
r 8000009c 17 8000008c
r 800000a0 18 00000009

// ==== bench/retire_checker.sv ====
// retire checker
// checks fetch request timing and address, and every retirement against the expected stream
`include "rv_defs.svh"
`default_nettype none

module retire_checker (
    input  wire             clk,
    input  wire             reset,
    input  wire             fetch_req,
    input  wire  [`RV_XLEN-1:0] fetch_addr,
    input  wire             retire_valid,
    input  wire rv_pkg::retire_t retire,
    output int              errors,
    output int              retired,
    output int              pending
);
    timeunit 1ns;
    timeprecision 100ps;

    rv_pkg::retire_t expect_q [$];
    rv_pkg::retire_t want;
    int              pushed = 0;
    logic            req_due;   // a request belongs in this cycle

    initial begin
        errors  = 0;
        retired = 0;
    end

    assign pending = pushed - retired;

    // rd 0 means no write, rd and wdata read as zero whenever we is low
    task automatic add_expected(input logic [`RV_XLEN-1:0] pc,
                                input logic [`RV_REG_ADDR_W-1:0] rd,
                                input logic [`RV_XLEN-1:0] value,
                                input logic illegal);
        rv_pkg::retire_t rec;
        rec         = '0;
        rec.pc      = pc;
        rec.illegal = illegal;
        rec.we      = !illegal && (rd != '0);
        if (rec.we) begin
            rec.rd    = rd;
            rec.wdata = value;
        end
        expect_q.push_back(rec);
        pushed++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s at pc %h: got %h, expected %h", name, retire.pc, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            req_due = 1'b1;                  // first cycle out of reset fetches
        end else begin
            // exactly one request, right after reset or a retirement
            compare_field("fetch_req", 32'(fetch_req), 32'(req_due));
            if (fetch_req && expect_q.size() != 0) begin
                compare_field("fetch_addr", fetch_addr, expect_q[0].pc);
            end
            req_due = retire_valid;
            if (retire_valid) begin
                retired++;
                if (expect_q.size() == 0) begin
                    $display("core retired pc %h after the expected stream ran out", retire.pc);
                    errors++;
                end else begin
                    want = expect_q.pop_front();
                    compare_field("pc", retire.pc, want.pc);
                    compare_field("we", 32'(retire.we), 32'(want.we));
                    compare_field("rd", 32'(retire.rd), 32'(want.rd));
                    compare_field("wdata", retire.wdata, want.wdata);
                    compare_field("illegal", 32'(retire.illegal), 32'(want.illegal));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_top.sv ====
// testbench for the RV32I core
// program and expected retirements come from a file, fetches answered after a random delay
`include "rv_defs.svh"
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [`RV_XLEN-1:0] NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0
    localparam int REQ_LIMIT = 64;     // cycles without a fetch request
    localparam int RUN_LIMIT = 2000;   // cycles for the whole program

    logic                clk = 1'b0;
    logic                reset;
    logic                fetch_req;
    logic [`RV_XLEN-1:0] fetch_addr;
    logic                fetch_valid;
    logic [`RV_XLEN-1:0] fetch_data;
    logic                retire_valid;
    rv_pkg::retire_t     retire;

    logic [`RV_XLEN-1:0] imem [logic [`RV_XLEN-1:0]];   // sparse, unloaded reads give a nop
    logic [15:0]         lfsr;
    int                  errors;
    int                  retired;
    int                  pending;
    int                  tb_errors;
    bit                  fetch_stalled;

    always #2 clk = ~clk;

    rv_core dut (
        .clk          (clk),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    retire_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .retire_valid (retire_valid),
        .retire       (retire),
        .errors       (errors),
        .retired      (retired),
        .pending      (pending)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [`RV_XLEN-1:0] fetch_word(input logic [`RV_XLEN-1:0] addr);
        return imem.exists(addr) ? imem[addr] : NOP_WORD;
    endfunction

    task automatic load_program(output bit ok);
        int                    fd;
        int                    n;
        string                 line;
        logic [`RV_XLEN-1:0]   addr;
        logic [`RV_XLEN-1:0]   word;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [63:0]           val_txt;
        ok = 1'b0;
        fd = $fopen("bench/program_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/program_input.txt");
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "p") begin
                    n = $sscanf(line, "p %h %h", addr, word);
                    imem[addr] = word;
                end else if (n > 0 && line.getc(0) == "r") begin
                    n = $sscanf(line, "r %h %d %s", addr, rd, val_txt);
                    if (val_txt == 64'h78) begin          // "x" marks an illegal word
                        u_checker.add_expected(addr, rd, '0, 1'b1);
                    end else begin
                        n = $sscanf(line, "r %h %d %h", addr, rd, word);
                        u_checker.add_expected(addr, rd, word, 1'b0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic end_run();
        $display("run ended: %0d retired, %0d checker errors, %0d testbench errors",
                 retired, errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        bit loaded;
        bit stalled;
        int cycles;
        reset       <= 1'b1;
        fetch_valid <= 1'b0;
        fetch_data  <= NOP_WORD;
        tb_errors   = 0;
        stalled     = 1'b0;
        cycles      = 0;
        load_program(loaded);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // counters settle by the falling edge
        while (loaded && pending != 0 && !stalled && !fetch_stalled) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("core stopped retiring, %0d expected retirements missing", pending);
                stalled = 1'b1;
            end
        end
        if (!loaded || stalled || fetch_stalled) begin
            tb_errors++;
        end
        end_run();
    end

    // instruction memory, one response per request
    initial begin
        logic [1:0]          bits;
        logic [`RV_XLEN-1:0] addr;
        int                  cycles;
        bit                  seen;
        lfsr          = 16'd81;
        bits          = 2'b00;
        fetch_stalled = 1'b0;
        while (!fetch_stalled) begin
            seen   = 1'b0;
            cycles = 0;
            while (!seen && !fetch_stalled) begin
                @(posedge clk);
                if (!reset && fetch_req) begin
                    seen = 1'b1;
                end else begin
                    cycles++;
                    if (cycles > REQ_LIMIT) begin
                        $display("core stopped requesting instructions");
                        fetch_stalled = 1'b1;
                    end
                end
            end
            if (seen) begin
                addr = fetch_addr;
                for (int i = 0; i < 2; i++) begin
                    bits = {bits[0], lfsr[0]};
                    lfsr = lfsr_next(lfsr);
                end
                repeat (bits) @(posedge clk);   // answer 1 to 4 cycles after the request
                fetch_valid <= 1'b1;
                fetch_data  <= fetch_word(addr);
                @(posedge clk);
                fetch_valid <= 1'b0;
                fetch_data  <= NOP_WORD;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || grep -q ">>> PASS" sim.log

// ==== src/alu.sv ====
// 32-bit integer ALU
// the ten RV32I operations, shift amount from b[4:0]
`include "rv_defs.svh"
`default_nettype none

module alu (
    input  wire  [`RV_XLEN-1:0] a,
    input  wire  [`RV_XLEN-1:0] b,
    input  wire  rv_pkg::alu_op_t op,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);   // sign fill
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
// instruction decoder
// slices fields, classifies the format, builds the immediate and picks the ALU op
`include "rv_defs.svh"
`default_nettype none

module decode_unit (
    input  wire  [`RV_XLEN-1:0] inst,
    output rv_pkg::decoded_t    dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        dec         = '0;
        dec.opcode  = opcode;
        dec.funct3  = funct3;
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.alu_op  = rv_pkg::ALU_ADD;
        dec.illegal = 1'b0;

        case (opcode)
            `RV_OP_OP:                  dec.fmt = rv_pkg::FMT_R;
            `RV_OP_OP_IMM, `RV_OP_JALR: dec.fmt = rv_pkg::FMT_I;
            `RV_OP_BRANCH:              dec.fmt = rv_pkg::FMT_B;
            `RV_OP_LUI, `RV_OP_AUIPC:   dec.fmt = rv_pkg::FMT_U;
            `RV_OP_JAL:                 dec.fmt = rv_pkg::FMT_J;
            default: begin
                dec.fmt     = rv_pkg::FMT_NONE;
                dec.illegal = 1'b1;    // loads, stores, system and the rest
            end
        endcase

        case (dec.fmt)
            rv_pkg::FMT_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::FMT_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::FMT_U: dec.imm = {inst[31:12], 12'h000};
            rv_pkg::FMT_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:       dec.imm = '0;
        endcase

        // only arithmetic opcodes use funct3 as an ALU selector
        if (opcode == `RV_OP_OP || opcode == `RV_OP_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (opcode == `RV_OP_OP && funct7 == 7'b0100000) begin
                        dec.alu_op = rv_pkg::ALU_SUB;
                    end
                end
                3'b001: dec.alu_op = rv_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_pkg::ALU_SLT;
                3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
                3'b100: dec.alu_op = rv_pkg::ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: dec.alu_op = rv_pkg::ALU_OR;
                3'b111: dec.alu_op = rv_pkg::ALU_AND;
                default: dec.alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
// execute and write-back
// ALU operands, branch decision, next pc, register write and retire record
`include "rv_defs.svh"
`default_nettype none

module exec_unit (
    input  wire  rv_pkg::decoded_t dec,
    input  wire  [`RV_XLEN-1:0]    pc,
    input  wire  [`RV_XLEN-1:0]    rs1_data,
    input  wire  [`RV_XLEN-1:0]    rs2_data,
    output logic [`RV_XLEN-1:0]    next_pc,
    output logic                   rf_we,
    output logic [`RV_XLEN-1:0]    rf_wdata,
    output rv_pkg::retire_t        ret
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] snpc;
    logic [`RV_XLEN-1:0] jump_target;
    logic                jump_taken;
    logic                is_jalr;
    logic                wb_en;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign snpc    = pc + 32'd4;
    assign is_jalr = (dec.opcode == `RV_OP_JALR);

    always_comb begin
        alu_a      = rs1_data;
        alu_b      = rs2_data;
        jump_taken = 1'b0;
        case (dec.fmt)
            rv_pkg::FMT_R: ;                     // rs1 op rs2
            rv_pkg::FMT_I: begin
                alu_b      = dec.imm;
                jump_taken = is_jalr;
            end
            rv_pkg::FMT_U: begin
                alu_a = (dec.opcode == `RV_OP_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            rv_pkg::FMT_J: begin
                alu_a      = pc;
                alu_b      = dec.imm;
                jump_taken = 1'b1;
            end
            rv_pkg::FMT_B: begin
                alu_a = pc;                      // target, compare done below
                alu_b = dec.imm;
                case (dec.funct3)
                    3'b000:  jump_taken = (rs1_data == rs2_data);
                    3'b001:  jump_taken = (rs1_data != rs2_data);
                    3'b100:  jump_taken = ($signed(rs1_data) < $signed(rs2_data));
                    3'b101:  jump_taken = ($signed(rs1_data) >= $signed(rs2_data));
                    3'b110:  jump_taken = (rs1_data < rs2_data);
                    3'b111:  jump_taken = (rs1_data >= rs2_data);
                    default: jump_taken = 1'b0;
                endcase
            end
            default: ;                           // illegal falls through to pc+4
        endcase
    end

    assign jump_target = is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : alu_result;
    assign next_pc     = jump_taken ? jump_target : snpc;

    // branches never write, jumps link pc+4
    assign wb_en    = (dec.fmt == rv_pkg::FMT_R) || (dec.fmt == rv_pkg::FMT_I)
                   || (dec.fmt == rv_pkg::FMT_U) || (dec.fmt == rv_pkg::FMT_J);
    assign rf_wdata = (is_jalr || dec.fmt == rv_pkg::FMT_J) ? snpc : alu_result;
    assign rf_we    = wb_en && (dec.rd != '0);   // x0 stays zero

    always_comb begin
        ret         = '0;
        ret.pc      = pc;
        ret.we      = rf_we;
        ret.illegal = dec.illegal;
        if (rf_we) begin
            ret.rd    = dec.rd;
            ret.wdata = rf_wdata;
        end
    end

    // catches a bad B/J immediate from decode or a misaligned jalr base
    always_comb begin
        if (jump_taken) begin
            a_target_aligned: assert final (next_pc[1:0] == 2'b00)
                else $error("misaligned jump target %h at pc %h", next_pc, pc);
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
// instruction fetch sequencer
// holds the pc, issues one request and waits for a response of any latency
`include "rv_defs.svh"
`default_nettype none

module fetch_unit (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 fetch_valid,
    input  wire  [`RV_XLEN-1:0] next_pc,
    output logic                fetch_req,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] fetch_addr
);

    typedef enum logic {
        S_REQUEST,
        S_WAIT
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_REQUEST;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                S_REQUEST: state <= S_WAIT;    // request lasts one cycle
                S_WAIT: begin
                    if (fetch_valid) begin     // instruction retires this cycle
                        state <= S_REQUEST;
                        pc    <= next_pc;
                    end
                end
                default: state <= S_REQUEST;
            endcase
        end
    end

    assign fetch_req  = (state == S_REQUEST);
    assign fetch_addr = pc;

    // responder must only answer an outstanding request
    a_valid_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        fetch_valid |-> (state == S_WAIT)
    ) else $error("fetch_valid outside WAIT");

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// integer register file
// two asynchronous read ports, one write port, x0 reads as zero
`include "rv_defs.svh"
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       we,
    input  wire  [`RV_REG_ADDR_W-1:0] waddr,
    input  wire  [`RV_REG_ADDR_W-1:0] raddr1,
    input  wire  [`RV_REG_ADDR_W-1:0] raddr2,
    input  wire  [`RV_XLEN-1:0]       wdata,
    output logic [`RV_XLEN-1:0]       rdata1,
    output logic [`RV_XLEN-1:0]       rdata2
);

    localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

    logic [`RV_XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // execute drops rd == 0 writes before they get here
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset)
        we |-> (waddr != '0)
    ) else $error("register file written at x0");

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
// single-cycle RV32I core
// fetch, decode, register file and execute around a request/response fetch port
`include "rv_defs.svh"
`default_nettype none

module rv_core (
    input  wire                 clk,
    input  wire                 reset,
    output logic                fetch_req,
    output logic [`RV_XLEN-1:0] fetch_addr,
    input  wire                 fetch_valid,
    input  wire  [`RV_XLEN-1:0] fetch_data,
    output logic                retire_valid,
    output rv_pkg::retire_t     retire
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] rf_wdata;
    logic                rf_we;
    rv_pkg::decoded_t    dec;
    rv_pkg::retire_t     ret;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .next_pc     (next_pc),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .fetch_addr  (fetch_addr)
    );

    decode_unit u_decode (
        .inst (fetch_data),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we && fetch_valid),   // commit only with the response
        .waddr  (dec.rd),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata  (rf_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit u_exec (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .rf_we    (rf_we),
        .rf_wdata (rf_wdata),
        .ret      (ret)
    );

    assign retire_valid = fetch_valid;   // retires in the response cycle
    assign retire       = ret;

endmodule

`default_nettype wire

// ==== src/rv_defs.svh ====
// RV32I core constants
// data width, register count, reset vector and the opcodes this core decodes
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_RESET_PC     32'h8000_0000

// major opcodes, inst[6:0]
`define RV_OP_OP        7'b0110011
`define RV_OP_OP_IMM    7'b0010011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011

`endif

// ==== src/rv_pkg.sv ====
// RV32I core types
// instruction format and ALU op encodings, decoded instruction and retire record
`include "rv_defs.svh"
`default_nettype none

package rv_pkg;

    typedef enum logic [2:0] {
        FMT_R,      // reg-reg
        FMT_I,      // reg-imm and jalr
        FMT_B,      // conditional branch
        FMT_U,      // lui, auipc
        FMT_J,      // jal
        FMT_NONE    // unknown opcode
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // everything execute needs from one instruction word
    typedef struct packed {
        logic [6:0]                opcode;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_XLEN-1:0]       imm;     // sign extended
        inst_fmt_t                 fmt;
        alu_op_t                   alu_op;
        logic                      illegal;
    } decoded_t;

    // one retired instruction, rd and wdata are zero when we is low
    typedef struct packed {
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       wdata;
        logic                      we;
        logic                      illegal;
    } retire_t;

endpackage

`default_nettype wire
